// ==== hw/gpio_macros.svh ====
// gpio register map and pad width
// shared by the register block and the checker
`ifndef GPIO_MACROS_SVH
`define GPIO_MACROS_SVH

// pad and data bus width
`define GPIO_W 32

////////////////////////////////////////////////////////////
// register byte offsets, word aligned
////////////////////////////////////////////////////////////

// input side
`define GPIO_OFS_INPUT_VAL  8'h00
`define GPIO_OFS_INPUT_EN   8'h04
// output side
`define GPIO_OFS_OUTPUT_EN  8'h08
`define GPIO_OFS_OUTPUT_VAL 8'h0C
// interrupt enables and pending bits, one pair per event kind
`define GPIO_OFS_RISE_IE    8'h18
`define GPIO_OFS_RISE_IP    8'h1C
`define GPIO_OFS_FALL_IE    8'h20
`define GPIO_OFS_FALL_IP    8'h24
`define GPIO_OFS_HIGH_IE    8'h28
`define GPIO_OFS_HIGH_IP    8'h2C
`define GPIO_OFS_LOW_IE     8'h30
`define GPIO_OFS_LOW_IP     8'h34
// alternate function routing and output polarity
`define GPIO_OFS_IOF_EN     8'h38
`define GPIO_OFS_IOF_SEL    8'h3C
`define GPIO_OFS_OUT_XOR    8'h40

`endif

// ==== hw/gpio_pkg.sv ====
// gpio types shared across the register, pad and interrupt blocks
`include "gpio_macros.svh"

package gpio_pkg;

  ////////////////////////////////////////////////////////////
  // bus side
  ////////////////////////////////////////////////////////////

  // one apb request as seen by the slave, 43 bits
  typedef struct packed {
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [7:0]          paddr;
    logic [`GPIO_W-1:0]  pwdata;
  } apb_req_t;

  ////////////////////////////////////////////////////////////
  // register contents
  ////////////////////////////////////////////////////////////

  // the ten writable words
  typedef struct packed {
    logic [`GPIO_W-1:0] input_en;
    logic [`GPIO_W-1:0] output_en;
    logic [`GPIO_W-1:0] output_val;
    logic [`GPIO_W-1:0] rise_ie;
    logic [`GPIO_W-1:0] fall_ie;
    logic [`GPIO_W-1:0] high_ie;
    logic [`GPIO_W-1:0] low_ie;
    logic [`GPIO_W-1:0] iof_en;
    logic [`GPIO_W-1:0] iof_sel;
    logic [`GPIO_W-1:0] out_xor;
  } gpio_cfg_t;

  // synchronized input, now is stage two and prev is stage three
  typedef struct packed {
    logic [`GPIO_W-1:0] now;
    logic [`GPIO_W-1:0] prev;
  } gpio_sample_t;

  // pending bits per event kind, also used as clear masks
  typedef struct packed {
    logic [`GPIO_W-1:0] rise;
    logic [`GPIO_W-1:0] fall;
    logic [`GPIO_W-1:0] high;
    logic [`GPIO_W-1:0] low;
  } gpio_ip_t;

endpackage

// ==== hw/gpio_apb_regs.sv ====
// gpio register block
// apb decode, configuration words, registered read data and pending clear masks
`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpio_apb_regs
  import gpio_pkg::*;
(
  input  logic               PCLK,
  input  logic               PRESETn,
  input  apb_req_t           apb_req,
  input  logic [`GPIO_W-1:0] input_val,
  input  gpio_ip_t           ip,
  output logic [`GPIO_W-1:0] prdata,
  output logic               pready,
  output gpio_cfg_t          cfg,
  output gpio_ip_t           ip_clr
);

  // word offset, byte lane bits dropped
  logic [7:0]          entry;
  // write strobe for the access phase
  logic                wr_en;
  // word selected for the next prdata
  logic [`GPIO_W-1:0]  rd_word;

  assign entry  = {apb_req.paddr[7:2], 2'b00};
  assign wr_en  = apb_req.psel & apb_req.penable & apb_req.pwrite;
  // no wait states
  assign pready = 1'b1;

  ////////////////////////////////////////////////////////////
  // configuration writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      cfg <= '0;
    end else if (wr_en) begin
      case (entry)
        `GPIO_OFS_INPUT_EN:   cfg.input_en   <= apb_req.pwdata;
        `GPIO_OFS_OUTPUT_EN:  cfg.output_en  <= apb_req.pwdata;
        `GPIO_OFS_OUTPUT_VAL: cfg.output_val <= apb_req.pwdata;
        `GPIO_OFS_RISE_IE:    cfg.rise_ie    <= apb_req.pwdata;
        `GPIO_OFS_FALL_IE:    cfg.fall_ie    <= apb_req.pwdata;
        `GPIO_OFS_HIGH_IE:    cfg.high_ie    <= apb_req.pwdata;
        `GPIO_OFS_LOW_IE:     cfg.low_ie     <= apb_req.pwdata;
        `GPIO_OFS_IOF_EN:     cfg.iof_en     <= apb_req.pwdata;
        `GPIO_OFS_IOF_SEL:    cfg.iof_sel    <= apb_req.pwdata;
        `GPIO_OFS_OUT_XOR:    cfg.out_xor    <= apb_req.pwdata;
        // input_val, pending words and holes are not stored here
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // pending clear masks
  ////////////////////////////////////////////////////////////

  // write data lands on the addressed pending field, zero otherwise
  always_comb begin
    ip_clr = '0;
    if (wr_en) begin
      case (entry)
        `GPIO_OFS_RISE_IP: ip_clr.rise = apb_req.pwdata;
        `GPIO_OFS_FALL_IP: ip_clr.fall = apb_req.pwdata;
        `GPIO_OFS_HIGH_IP: ip_clr.high = apb_req.pwdata;
        `GPIO_OFS_LOW_IP:  ip_clr.low  = apb_req.pwdata;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////

  // select by current address, every cycle
  always_comb begin
    case (entry)
      `GPIO_OFS_INPUT_VAL:  rd_word = input_val;
      `GPIO_OFS_INPUT_EN:   rd_word = cfg.input_en;
      `GPIO_OFS_OUTPUT_EN:  rd_word = cfg.output_en;
      `GPIO_OFS_OUTPUT_VAL: rd_word = cfg.output_val;
      `GPIO_OFS_RISE_IE:    rd_word = cfg.rise_ie;
      `GPIO_OFS_RISE_IP:    rd_word = ip.rise;
      `GPIO_OFS_FALL_IE:    rd_word = cfg.fall_ie;
      `GPIO_OFS_FALL_IP:    rd_word = ip.fall;
      `GPIO_OFS_HIGH_IE:    rd_word = cfg.high_ie;
      `GPIO_OFS_HIGH_IP:    rd_word = ip.high;
      `GPIO_OFS_LOW_IE:     rd_word = cfg.low_ie;
      `GPIO_OFS_LOW_IP:     rd_word = ip.low;
      `GPIO_OFS_IOF_EN:     rd_word = cfg.iof_en;
      `GPIO_OFS_IOF_SEL:    rd_word = cfg.iof_sel;
      `GPIO_OFS_OUT_XOR:    rd_word = cfg.out_xor;
      // unmapped offsets read zero
      default:              rd_word = '0;
    endcase
  end

  // setup cycle address gives valid data in the access cycle
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      prdata <= '0;
    end else begin
      prdata <= rd_word;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // master must select before enabling
  a_penable_needs_psel: assert property (
    @(posedge PCLK) disable iff (!PRESETn)
    $rose(apb_req.penable) |-> apb_req.psel
  ) else $error("penable rose without psel");

endmodule

// ==== hw/gpio_pad_ctrl.sv ====
// gpio pad control
// gated three-stage input synchronizer, alternate function output mux and polarity
`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpio_pad_ctrl
  import gpio_pkg::*;
(
  input  logic               PCLK,
  input  logic               PRESETn,
  input  gpio_cfg_t          cfg,
  input  logic [`GPIO_W-1:0] gpio_in,
  input  logic [`GPIO_W-1:0] iof0,
  input  logic [`GPIO_W-1:0] iof1,
  output gpio_sample_t       sample,
  output logic [`GPIO_W-1:0] gpio_out,
  output logic [`GPIO_W-1:0] gpio_en
);

  // pad input after enable gating
  logic [`GPIO_W-1:0] in_gated;
  // first synchronizer stage, may go metastable
  logic [`GPIO_W-1:0] sync1;
  // iof0 or iof1 per bit
  logic [`GPIO_W-1:0] iof_out;
  // iof result or plain output value per bit
  logic [`GPIO_W-1:0] pad_val;

  ////////////////////////////////////////////////////////////
  // input path
  ////////////////////////////////////////////////////////////

  // disabled bits never toggle the synchronizer
  assign in_gated = gpio_in & cfg.input_en;

  // three stages, now taps stage two and prev taps stage three
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      sync1       <= '0;
      sample.now  <= '0;
      sample.prev <= '0;
    end else begin
      sync1       <= in_gated;
      sample.now  <= sync1;
      sample.prev <= sample.now;
    end
  end

  ////////////////////////////////////////////////////////////
  // output path
  ////////////////////////////////////////////////////////////

  // iof_sel high picks iof1
  assign iof_out  = (cfg.iof_sel & iof1) | (~cfg.iof_sel & iof0);
  // iof_en high hands the pad to the alternate function
  assign pad_val  = (cfg.iof_en & iof_out) | (~cfg.iof_en & cfg.output_val);
  // per-bit polarity flip
  assign gpio_out = pad_val ^ cfg.out_xor;
  // drive enable straight from the register
  assign gpio_en  = cfg.output_en;

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // a bit disabled now reaches prev as zero three edges later
  property p_disabled_bits_zero;
    logic [`GPIO_W-1:0] dis;
    @(posedge PCLK) disable iff (!PRESETn)
    (1'b1, dis = ~cfg.input_en) |-> ##3 ((sample.prev & dis) == '0);
  endproperty

  a_disabled_bits_zero: assert property (p_disabled_bits_zero)
    else $error("disabled input bit reached sample.prev");

endmodule

// ==== hw/gpio_irq.sv ====
// gpio interrupt block
// rise, fall, high and low pending bits with write-one-to-clear and one irq level
`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpio_irq
  import gpio_pkg::*;
(
  input  logic         PCLK,
  input  logic         PRESETn,
  input  gpio_sample_t sample,
  input  gpio_cfg_t    cfg,
  input  gpio_ip_t     ip_clr,
  output gpio_ip_t     ip,
  output logic         gpio_irq
);

  // event conditions seen this cycle
  gpio_ip_t ev;
  // enables lined up with the pending fields
  gpio_ip_t ie;

  // a nonzero mask clears and blocks setting for that register this cycle
  function automatic logic [`GPIO_W-1:0] next_ip(
    input logic [`GPIO_W-1:0] cur,
    input logic [`GPIO_W-1:0] clr,
    input logic [`GPIO_W-1:0] cond
  );
    if (|clr) begin
      return cur & ~clr;
    end
    return cur | cond;
  endfunction

  assign ev.rise = sample.now & ~sample.prev;
  assign ev.fall = ~sample.now & sample.prev;
  assign ev.high = sample.prev;
  // prev resets low, so low pending bits fill right after reset
  assign ev.low  = ~sample.prev;

  assign ie.rise = cfg.rise_ie;
  assign ie.fall = cfg.fall_ie;
  assign ie.high = cfg.high_ie;
  assign ie.low  = cfg.low_ie;

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      ip <= '0;
    end else begin
      ip.rise <= next_ip(ip.rise, ip_clr.rise, ev.rise);
      ip.fall <= next_ip(ip.fall, ip_clr.fall, ev.fall);
      ip.high <= next_ip(ip.high, ip_clr.high, ev.high);
      ip.low  <= next_ip(ip.low, ip_clr.low, ev.low);
    end
  end

  // any enabled pending bit raises the line
  assign gpio_irq = |(ip & ie);

  // cleared bits stay clear for one edge unless their event was live
  property p_clear_takes;
    gpio_ip_t m;
    @(posedge PCLK) disable iff (!PRESETn)
    (1'b1, m = ip_clr & ~ev) |=> ((ip & m) == '0);
  endproperty

  a_clear_takes: assert property (p_clear_takes)
    else $error("pending bit survived write-one-to-clear");

endmodule

// ==== hw/gpio_apb.sv ====
// gpio peripheral top
// ties the apb register block to the pad control and the interrupt logic
`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpio_apb
  import gpio_pkg::*;
(
  input  logic               PCLK,
  input  logic               PRESETn,
  input  apb_req_t           apb_req,
  input  logic [`GPIO_W-1:0] iof0,
  input  logic [`GPIO_W-1:0] iof1,
  input  logic [`GPIO_W-1:0] gpio_in,
  output logic [`GPIO_W-1:0] prdata,
  output logic               pready,
  output logic [`GPIO_W-1:0] gpio_out,
  output logic [`GPIO_W-1:0] gpio_en,
  output logic               gpio_irq
);

  // configuration words from the register block
  gpio_cfg_t    cfg;
  // synchronized input, prev doubles as input_val
  gpio_sample_t sample;
  // pending bits and their clear masks
  gpio_ip_t     ip;
  gpio_ip_t     ip_clr;

  gpio_apb_regs u_regs (
    .PCLK      (PCLK),
    .PRESETn   (PRESETn),
    .apb_req   (apb_req),
    .input_val (sample.prev),
    .ip        (ip),
    .prdata    (prdata),
    .pready    (pready),
    .cfg       (cfg),
    .ip_clr    (ip_clr)
  );

  gpio_pad_ctrl u_pad (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .cfg      (cfg),
    .gpio_in  (gpio_in),
    .iof0     (iof0),
    .iof1     (iof1),
    .sample   (sample),
    .gpio_out (gpio_out),
    .gpio_en  (gpio_en)
  );

  gpio_irq u_irq (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .sample   (sample),
    .cfg      (cfg),
    .ip_clr   (ip_clr),
    .ip       (ip),
    .gpio_irq (gpio_irq)
  );

endmodule

// ==== verification/gpio_apb_checker.sv ====
// gpio checker
// shadow register and pad model of the gpio, compares the dut ports every cycle
`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpio_apb_checker
  import gpio_pkg::*;
(
  input  logic               PCLK,
  input  logic               PRESETn,
  input  apb_req_t           apb_req,
  input  logic [`GPIO_W-1:0] iof0,
  input  logic [`GPIO_W-1:0] iof1,
  input  logic [`GPIO_W-1:0] gpio_in,
  input  logic [`GPIO_W-1:0] prdata,
  input  logic               pready,
  input  logic [`GPIO_W-1:0] gpio_out,
  input  logic [`GPIO_W-1:0] gpio_en,
  input  logic               gpio_irq,
  output int                 errors
);

  // shadow of the writable words
  gpio_cfg_t          shadow;
  // synchronizer model, three stages
  logic [`GPIO_W-1:0] m_s1;
  logic [`GPIO_W-1:0] m_now;
  logic [`GPIO_W-1:0] m_prev;
  // pending model
  gpio_ip_t           m_ip;
  // word expected in prdata, captured at the setup edge
  logic [`GPIO_W-1:0] exp_rd;
  logic [7:0]         entry;
  logic               wr;
  int                 err_cnt = 0;

  assign entry  = {apb_req.paddr[7:2], 2'b00};
  assign wr     = apb_req.psel & apb_req.penable & apb_req.pwrite;
  assign errors = err_cnt;

  ////////////////////////////////////////////////////////////
  // reference functions
  ////////////////////////////////////////////////////////////

  // expected read word for one offset
  function automatic logic [`GPIO_W-1:0] ref_read(input logic [7:0] ofs);
    case (ofs)
      `GPIO_OFS_INPUT_VAL:  return m_prev;
      `GPIO_OFS_INPUT_EN:   return shadow.input_en;
      `GPIO_OFS_OUTPUT_EN:  return shadow.output_en;
      `GPIO_OFS_OUTPUT_VAL: return shadow.output_val;
      `GPIO_OFS_RISE_IE:    return shadow.rise_ie;
      `GPIO_OFS_RISE_IP:    return m_ip.rise;
      `GPIO_OFS_FALL_IE:    return shadow.fall_ie;
      `GPIO_OFS_FALL_IP:    return m_ip.fall;
      `GPIO_OFS_HIGH_IE:    return shadow.high_ie;
      `GPIO_OFS_HIGH_IP:    return m_ip.high;
      `GPIO_OFS_LOW_IE:     return shadow.low_ie;
      `GPIO_OFS_LOW_IP:     return m_ip.low;
      `GPIO_OFS_IOF_EN:     return shadow.iof_en;
      `GPIO_OFS_IOF_SEL:    return shadow.iof_sel;
      `GPIO_OFS_OUT_XOR:    return shadow.out_xor;
      default:              return '0;
    endcase
  endfunction

  // expected pad value, bit by bit
  function automatic logic [`GPIO_W-1:0] ref_pad_out(
    input gpio_cfg_t          c,
    input logic [`GPIO_W-1:0] f0,
    input logic [`GPIO_W-1:0] f1
  );
    logic [`GPIO_W-1:0] res;
    logic               v;
    for (int i = 0; i < `GPIO_W; i++) begin
      if (c.iof_en[i]) begin
        v = c.iof_sel[i] ? f1[i] : f0[i];
      end else begin
        v = c.output_val[i];
      end
      res[i] = v ^ c.out_xor[i];
    end
    return res;
  endfunction

  // write data when this pending offset is written, else zero
  function automatic logic [`GPIO_W-1:0] clear_mask(input logic [7:0] ofs);
    return (wr && entry == ofs) ? apb_req.pwdata : '0;
  endfunction

  // a clearing write wins over new events for that register
  function automatic logic [`GPIO_W-1:0] apply_pending(
    input logic [`GPIO_W-1:0] cur,
    input logic [`GPIO_W-1:0] clr,
    input logic [`GPIO_W-1:0] cond
  );
    if (clr != '0) begin
      return cur & ~clr;
    end
    return cur | cond;
  endfunction

  function automatic logic irq_expected();
    return |((m_ip.rise & shadow.rise_ie) | (m_ip.fall & shadow.fall_ie) |
             (m_ip.high & shadow.high_ie) | (m_ip.low & shadow.low_ie));
  endfunction

  ////////////////////////////////////////////////////////////
  // model update on the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      shadow <= '0;
      m_s1   <= '0;
      m_now  <= '0;
      m_prev <= '0;
      m_ip   <= '0;
      exp_rd <= '0;
    end else begin
      // read data follows the address of this cycle
      exp_rd <= ref_read(entry);
      m_s1   <= gpio_in & shadow.input_en;
      m_now  <= m_s1;
      m_prev <= m_now;
      m_ip.rise <= apply_pending(m_ip.rise, clear_mask(`GPIO_OFS_RISE_IP), m_now & ~m_prev);
      m_ip.fall <= apply_pending(m_ip.fall, clear_mask(`GPIO_OFS_FALL_IP), ~m_now & m_prev);
      m_ip.high <= apply_pending(m_ip.high, clear_mask(`GPIO_OFS_HIGH_IP), m_prev);
      m_ip.low  <= apply_pending(m_ip.low, clear_mask(`GPIO_OFS_LOW_IP), ~m_prev);
      if (wr) begin
        case (entry)
          `GPIO_OFS_INPUT_EN:   shadow.input_en   <= apb_req.pwdata;
          `GPIO_OFS_OUTPUT_EN:  shadow.output_en  <= apb_req.pwdata;
          `GPIO_OFS_OUTPUT_VAL: shadow.output_val <= apb_req.pwdata;
          `GPIO_OFS_RISE_IE:    shadow.rise_ie    <= apb_req.pwdata;
          `GPIO_OFS_FALL_IE:    shadow.fall_ie    <= apb_req.pwdata;
          `GPIO_OFS_HIGH_IE:    shadow.high_ie    <= apb_req.pwdata;
          `GPIO_OFS_LOW_IE:     shadow.low_ie     <= apb_req.pwdata;
          `GPIO_OFS_IOF_EN:     shadow.iof_en     <= apb_req.pwdata;
          `GPIO_OFS_IOF_SEL:    shadow.iof_sel    <= apb_req.pwdata;
          `GPIO_OFS_OUT_XOR:    shadow.out_xor    <= apb_req.pwdata;
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // comparing process
  ////////////////////////////////////////////////////////////

  task automatic report(input string name, input logic [`GPIO_W-1:0] exp,
                        input logic [`GPIO_W-1:0] act);
    err_cnt++;
    $display("mismatch %s expected %h actual %h at %0t", name, exp, act, $time);
  endtask

  // one step after the falling edge, stimulus has settled
  always @(negedge PCLK) begin
    #1;
    if (PRESETn) begin
      if (apb_req.psel && apb_req.penable && !apb_req.pwrite && prdata !== exp_rd) begin
        report($sformatf("prdata (offset %h)", entry), exp_rd, prdata);
      end
      if (pready !== 1'b1) begin
        err_cnt++;
        $display("pready was low at %0t", $time);
      end
      if (gpio_out !== ref_pad_out(shadow, iof0, iof1)) begin
        report("gpio_out", ref_pad_out(shadow, iof0, iof1), gpio_out);
      end
      if (gpio_en !== shadow.output_en) begin
        report("gpio_en", shadow.output_en, gpio_en);
      end
      if (gpio_irq !== irq_expected()) begin
        report("gpio_irq", {31'b0, irq_expected()}, {31'b0, gpio_irq});
      end
    end
  end

endmodule

// ==== verification/gpio_apb_tb.sv ====
// gpio testbench
// apb and pad stimulus on falling edges, results checked by the checker module
`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpio_apb_tb
  import gpio_pkg::*;
();

  logic               PCLK;
  logic               PRESETn;
  apb_req_t           apb_req;
  logic [`GPIO_W-1:0] iof0;
  logic [`GPIO_W-1:0] iof1;
  logic [`GPIO_W-1:0] gpio_in;
  logic [`GPIO_W-1:0] prdata;
  logic               pready;
  logic [`GPIO_W-1:0] gpio_out;
  logic [`GPIO_W-1:0] gpio_en;
  logic               gpio_irq;
  int                 chk_errors;
  int                 timeouts = 0;

  gpio_apb uut (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .apb_req  (apb_req),
    .iof0     (iof0),
    .iof1     (iof1),
    .gpio_in  (gpio_in),
    .prdata   (prdata),
    .pready   (pready),
    .gpio_out (gpio_out),
    .gpio_en  (gpio_en),
    .gpio_irq (gpio_irq)
  );

  gpio_apb_checker chk (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .apb_req  (apb_req),
    .iof0     (iof0),
    .iof1     (iof1),
    .gpio_in  (gpio_in),
    .prdata   (prdata),
    .pready   (pready),
    .gpio_out (gpio_out),
    .gpio_en  (gpio_en),
    .gpio_irq (gpio_irq),
    .errors   (chk_errors)
  );

  // 4 ns clock
  initial begin
    PCLK = 1'b0;
    forever #2 PCLK = ~PCLK;
  end

  ////////////////////////////////////////////////////////////
  // bus and wait tasks
  ////////////////////////////////////////////////////////////

  // setup then access, one cycle each while pready holds
  task automatic apb_transfer(input logic wr, input logic [7:0] addr,
                              input logic [`GPIO_W-1:0] wdata,
                              output logic [`GPIO_W-1:0] rdata);
    int n;
    @(negedge PCLK);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge PCLK);
    apb_req.penable = 1'b1;
    n = 0;
    while (pready !== 1'b1 && n < 8) begin
      @(negedge PCLK);
      n++;
    end
    if (pready !== 1'b1) begin
      timeouts++;
      $display("timeout: no pready for the transfer at offset %h", addr);
    end
    rdata = prdata;
    @(negedge PCLK);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [`GPIO_W-1:0] data);
    logic [`GPIO_W-1:0] unused;
    apb_transfer(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [`GPIO_W-1:0] data);
    apb_transfer(1'b0, addr, '0, data);
  endtask

  // poll input_val until the synchronized input shows up
  task automatic wait_input_val(input logic [`GPIO_W-1:0] exp);
    logic [`GPIO_W-1:0] rd;
    int                 tries;
    tries = 0;
    apb_read(`GPIO_OFS_INPUT_VAL, rd);
    while (rd !== exp && tries < 12) begin
      apb_read(`GPIO_OFS_INPUT_VAL, rd);
      tries++;
    end
    if (rd !== exp) begin
      timeouts++;
      $display("timeout: input value never settled to %h", exp);
    end
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while (gpio_irq !== level && n < 16) begin
      @(negedge PCLK);
      n++;
    end
    if (gpio_irq !== level) begin
      timeouts++;
      $display("timeout: interrupt line never went to %0b", level);
    end
  endtask

  // the ten writable words by index
  function automatic logic [7:0] cfg_offset(input int idx);
    case (idx)
      0:       return `GPIO_OFS_INPUT_EN;
      1:       return `GPIO_OFS_OUTPUT_EN;
      2:       return `GPIO_OFS_OUTPUT_VAL;
      3:       return `GPIO_OFS_RISE_IE;
      4:       return `GPIO_OFS_FALL_IE;
      5:       return `GPIO_OFS_HIGH_IE;
      6:       return `GPIO_OFS_LOW_IE;
      7:       return `GPIO_OFS_IOF_EN;
      8:       return `GPIO_OFS_IOF_SEL;
      default: return `GPIO_OFS_OUT_XOR;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [`GPIO_W-1:0] rd;
    logic [`GPIO_W-1:0] ien;
    logic [`GPIO_W-1:0] pin;
    void'($urandom(32'h0873_179f));
    apb_req = '0;
    iof0    = '0;
    iof1    = '0;
    gpio_in = '0;
    PRESETn = 1'b0;
    repeat (2) @(posedge PCLK);
    @(negedge PCLK);
    PRESETn = 1'b1;

    // reset values, holes included
    for (int a = 0; a < 'h50; a += 4) begin
      apb_read(a[7:0], rd);
    end
    apb_write(`GPIO_OFS_LOW_IE, '1);
    wait_irq(1'b1);
    apb_write(`GPIO_OFS_LOW_IE, '0);
    wait_irq(1'b0);

    // random readback, then read-only and unmapped writes
    for (int k = 0; k < 10; k++) begin
      apb_write(cfg_offset(k), $urandom);
      apb_read(cfg_offset(k), rd);
    end
    apb_write(`GPIO_OFS_INPUT_VAL, $urandom);
    apb_write(8'h10, $urandom);
    apb_write(8'h14, $urandom);
    apb_write(8'h44, $urandom);
    apb_write(8'hFC, $urandom);
    apb_read(8'h10, rd);
    apb_read(8'h44, rd);
    apb_read(8'hFC, rd);
    for (int k = 0; k < 10; k++) begin
      apb_read(cfg_offset(k), rd);
    end

    // output mux against many iof combinations
    for (int i = 0; i < 40; i++) begin
      apb_write(`GPIO_OFS_IOF_EN, $urandom);
      apb_write(`GPIO_OFS_IOF_SEL, $urandom);
      apb_write(`GPIO_OFS_OUTPUT_VAL, $urandom);
      apb_write(`GPIO_OFS_OUT_XOR, $urandom);
      apb_write(`GPIO_OFS_OUTPUT_EN, $urandom);
      repeat (4) begin
        @(negedge PCLK);
        iof0 = $urandom;
        iof1 = $urandom;
      end
    end

    // gated input value
    for (int i = 0; i < 8; i++) begin
      ien = $urandom;
      apb_write(`GPIO_OFS_INPUT_EN, ien);
      pin = $urandom;
      @(negedge PCLK);
      gpio_in = pin;
      wait_input_val(pin & ien);
    end

    // interrupts, start from a quiet state
    for (int k = 3; k < 7; k++) begin
      apb_write(cfg_offset(k), '0);
    end
    apb_write(`GPIO_OFS_INPUT_EN, '1);
    @(negedge PCLK);
    gpio_in = '0;
    wait_input_val('0);
    apb_write(`GPIO_OFS_RISE_IP, '1);
    apb_write(`GPIO_OFS_FALL_IP, '1);
    apb_write(`GPIO_OFS_HIGH_IP, '1);
    wait_irq(1'b0);

    // rising edges, then partial and full clear
    pin = $urandom | 32'h1;
    apb_write(`GPIO_OFS_RISE_IE, '1);
    @(negedge PCLK);
    gpio_in = pin;
    wait_irq(1'b1);
    apb_read(`GPIO_OFS_RISE_IP, rd);
    apb_read(`GPIO_OFS_HIGH_IP, rd);
    apb_read(`GPIO_OFS_LOW_IP, rd);
    apb_write(`GPIO_OFS_RISE_IP, pin & $urandom);
    apb_read(`GPIO_OFS_RISE_IP, rd);
    apb_write(`GPIO_OFS_RISE_IP, '1);
    wait_irq(1'b0);

    // falling edges
    apb_write(`GPIO_OFS_FALL_IE, '1);
    @(negedge PCLK);
    gpio_in = '0;
    wait_irq(1'b1);
    apb_read(`GPIO_OFS_FALL_IP, rd);
    apb_write(`GPIO_OFS_FALL_IP, '1);
    wait_irq(1'b0);
    apb_write(`GPIO_OFS_RISE_IE, '0);
    apb_write(`GPIO_OFS_FALL_IE, '0);

    // high level, stale bits first, then a live level
    apb_write(`GPIO_OFS_HIGH_IE, '1);
    wait_irq(1'b1);
    apb_write(`GPIO_OFS_HIGH_IP, '1);
    wait_irq(1'b0);
    @(negedge PCLK);
    gpio_in = pin;
    wait_irq(1'b1);
    apb_read(`GPIO_OFS_HIGH_IP, rd);
    apb_write(`GPIO_OFS_HIGH_IE, '0);
    wait_irq(1'b0);

    // low level sets again right after a clear
    apb_write(`GPIO_OFS_LOW_IE, '1);
    wait_irq(1'b1);
    apb_write(`GPIO_OFS_LOW_IP, '1);
    apb_read(`GPIO_OFS_LOW_IP, rd);
    apb_write(`GPIO_OFS_LOW_IE, '0);
    wait_irq(1'b0);

    repeat (4) @(negedge PCLK);
    $display("errors %0d timeouts %0d", chk_errors, timeouts);
    if (chk_errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== Bender.yml ====
package:
  name: gpio_apb

sources:
  # package first, then leaf blocks, then the top level
  - include_dirs:
      - hw
    files:
      - hw/gpio_pkg.sv
      - hw/gpio_apb_regs.sv
      - hw/gpio_pad_ctrl.sv
      - hw/gpio_irq.sv
      - hw/gpio_apb.sv

  # testbench sources
  - target: test
    include_dirs:
      - hw
    files:
      - verification/gpio_apb_checker.sv
      - verification/gpio_apb_tb.sv

// ==== gpio_apb.f ====
+incdir+hw
hw/gpio_pkg.sv
hw/gpio_apb_regs.sv
hw/gpio_pad_ctrl.sv
hw/gpio_irq.sv
hw/gpio_apb.sv
verification/gpio_apb_checker.sv
verification/gpio_apb_tb.sv
